//--- hw/sample_buffer_pkg.sv
`default_nettype none

package sample_buffer_pkg;

    // width of one digitizer sample
    localparam int sample_bits = 12;

    // samples stored together in one memory word per channel
    localparam int mem_samples = 6;

    // one channel word holds six samples, sample 0 in the lowest bits
    // so a 72-bit memory word maps straight onto the packed array
    typedef logic [mem_samples-1:0][sample_bits-1:0] sample_word_t;

    // position inside the four-cycle memclk phase
    // phase 0 is the cycle carrying memclk_sync_i
    typedef logic [1:0] phase_t;

    // run control as seen on memclk
    typedef enum logic {
        run_stopped,
        run_active
    } run_state_t;

    // the readout machine waits for a request or walks a burst
    typedef enum logic {
        rd_idle,
        rd_burst
    } read_state_t;

    // each channel index adds this many cycles of output delay,
    // which keeps the channel outputs staggered like the old cascade did
    localparam int chan_stagger = 2;

endpackage

`default_nettype wire

//--- hw/sample_buffer_if.sv
`timescale 1ns/100ps
`default_nettype none

// write side of the channel memories
// the write sequencer owns every signal here
interface write_port_if #(
    parameter int nchan    = 4,
    parameter int addr_len = 10
);
    // high for every cycle of an active run
    logic                                         wr_en;
    logic [addr_len-1:0]                          wr_addr;
    sample_buffer_pkg::sample_word_t [nchan-1:0]  wr_data;
    // also tells the read side whether requests may be taken
    logic                                         running;

    modport src (
        output wr_en,
        output wr_addr,
        output wr_data,
        output running
    );

    modport mem (
        input wr_en,
        input wr_addr,
        input wr_data
    );

    modport ctl (
        input running
    );
endinterface

// read side of the channel memories plus the phase slot for readout
interface read_port_if #(
    parameter int addr_len = 10
);
    logic                rd_en;
    logic [addr_len-1:0] rd_addr;
    // one cycle after the request is taken, also the begin pulse
    logic                rd_start;
    // high in the phase where a request may be accepted
    logic                readout_slot;

    // the write sequencer owns the phase, so it flags the slot
    modport slot (
        output readout_slot
    );

    modport seq (
        output rd_en,
        output rd_addr,
        output rd_start,
        input  readout_slot
    );

    modport mem (
        input rd_en,
        input rd_addr
    );
endinterface

`default_nettype wire

//--- hw/write_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module write_sequencer #(
    parameter int nchan         = 4,
    parameter int addr_len      = 10,
    parameter int readout_phase = 0
) (
    input  wire logic                                        memclk,
    input  wire logic                                        run_rst_i,
    input  wire logic                                        run_stop_i,
    input  wire logic                                        memclk_sync_i,
    input  wire sample_buffer_pkg::sample_word_t [nchan-1:0] dat_i,
    output logic                                             event_rst_o,
    write_port_if.src                                        wr,
    read_port_if.slot                                        rd
);

    sample_buffer_pkg::phase_t     phase;
    sample_buffer_pkg::run_state_t run_state;
    logic [addr_len-1:0]           wr_addr;
    logic                          phase3;
    logic                          running;

    // the phase index follows the sync pulse
    // sync marks phase 0, so the cycle after it is phase 1
    always_ff @(posedge memclk) begin
        if (memclk_sync_i) begin
            phase <= 2'd1;
        end else begin
            phase <= phase + 2'd1;
        end
    end

    assign phase3 = (phase == 2'd3);

    // run commands are only looked at on phase 3
    // a run reset wins over a stop when both are present
    // outside phase 3 the run state holds its value
    always_ff @(posedge memclk) begin
        if (phase3) begin
            if (run_rst_i) begin
                run_state <= sample_buffer_pkg::run_active;
            end else if (run_stop_i) begin
                run_state <= sample_buffer_pkg::run_stopped;
            end
        end
    end

    assign running = (run_state == sample_buffer_pkg::run_active);

    // the event buffer is held in reset whenever we are not running
    assign event_rst_o = ~running;

    // the write address free-runs and wraps through the ring
    // a run reset on phase 3 puts it at zero for the first running cycle
    always_ff @(posedge memclk) begin
        if (phase3 && run_rst_i) begin
            wr_addr <= '0;
        end else begin
            wr_addr <= wr_addr + 1'b1;
        end
    end

    // while stopped the address keeps counting but nothing lands in memory
    assign wr.wr_en   = running;
    assign wr.wr_addr = wr_addr;
    // input data already arrives at memory width, one word per channel
    assign wr.wr_data = dat_i;
    assign wr.running = running;

    // readout is aligned to a fixed phase so the output timing is known
    assign rd.readout_slot = (phase == sample_buffer_pkg::phase_t'(readout_phase));

endmodule

`default_nettype wire

//--- hw/read_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module read_sequencer #(
    parameter int addr_len = 10,
    parameter int rd_len   = 12
) (
    input  wire logic                memclk,
    input  wire logic                run_rst_i,
    input  wire logic [addr_len-1:0] req_addr_i,
    input  wire logic                req_valid_i,
    output logic                     req_ready_o,
    output logic                     begin_o,
    write_port_if.ctl                wr,
    read_port_if.seq                 rd
);

    // wide enough to hold rd_len-1 even for very short bursts
    localparam int cnt_bits = (rd_len > 1) ? $clog2(rd_len) : 1;
    localparam logic [cnt_bits-1:0] last_cnt = cnt_bits'(rd_len - 1);

    sample_buffer_pkg::read_state_t rd_state;
    logic [cnt_bits-1:0]            burst_cnt;
    logic [addr_len-1:0]            start_addr;
    logic                           accept;

    // a request only goes through while running, idle and in the slot
    // this also avoids a stopped buffer taking a request it cannot serve
    assign req_ready_o = wr.running && (rd_state == sample_buffer_pkg::rd_idle) &&
                         rd.readout_slot;
    assign accept      = req_valid_i && req_ready_o;

    // reads always start on a four-word boundary
    assign start_addr = {req_addr_i[addr_len-1:2], 2'b00};

    // the begin pulse is just the registered accept
    assign begin_o = rd.rd_start;

    always_ff @(posedge memclk) begin
        if (run_rst_i) begin
            rd_state    <= sample_buffer_pkg::rd_idle;
            rd.rd_start <= 1'b0;
            rd.rd_en    <= 1'b0;
            burst_cnt   <= '0;
        end else begin
            rd.rd_start <= accept;
            if (!wr.running) begin
                // losing the run abandons any burst in flight
                rd_state <= sample_buffer_pkg::rd_idle;
                rd.rd_en <= 1'b0;
            end else begin
                case (rd_state)
                    sample_buffer_pkg::rd_idle: begin
                        if (accept) begin
                            rd_state <= sample_buffer_pkg::rd_burst;
                        end
                    end
                    sample_buffer_pkg::rd_burst: begin
                        if (rd.rd_start) begin
                            // first read address goes out the cycle after begin
                            rd.rd_en  <= 1'b1;
                            burst_cnt <= '0;
                        end else if (rd.rd_en) begin
                            if (burst_cnt == last_cnt) begin
                                // ready may come back from the next cycle on
                                rd.rd_en <= 1'b0;
                                rd_state <= sample_buffer_pkg::rd_idle;
                            end else begin
                                burst_cnt <= burst_cnt + 1'b1;
                            end
                        end
                    end
                    default: begin
                        rd_state <= sample_buffer_pkg::rd_idle;
                    end
                endcase
            end
        end
    end

    // the address is loaded on accept and steps once per issued read
    // it sits on the start address through the begin cycle
    always_ff @(posedge memclk) begin
        if (accept) begin
            rd.rd_addr <= start_addr;
        end else if (rd.rd_en) begin
            rd.rd_addr <= rd.rd_addr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/channel_memory.sv
`timescale 1ns/100ps
`default_nettype none

module channel_memory #(
    parameter int nchan    = 4,
    parameter int addr_len = 10
) (
    input  wire logic                                        memclk,
    input  wire logic                                        run_rst_i,
    write_port_if.mem                                        wr,
    read_port_if.mem                                         rd,
    output sample_buffer_pkg::sample_word_t [nchan-1:0]      dat_o,
    output logic [nchan-1:0]                                 dat_valid_o
);

    localparam int depth = 2 ** addr_len;

    // marks the cycle where the read registers hold fresh burst data
    logic rd_vld;

    always_ff @(posedge memclk) begin
        if (run_rst_i) begin
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= rd.rd_en;
        end
    end

    for (genvar c = 0; c < nchan; c++) begin : g_chan
        // channel c sits 1+2c stages behind the read register
        localparam int stages = 1 + sample_buffer_pkg::chan_stagger * c;

        sample_buffer_pkg::sample_word_t ring [depth];
        sample_buffer_pkg::sample_word_t rd_word;
        sample_buffer_pkg::sample_word_t dly_data [stages];
        logic [stages-1:0]               dly_vld;

        // all channels share the write and read addresses
        // the read samples the array before this edge's write lands,
        // so a read and a write to one address in one cycle returns the old word
        always_ff @(posedge memclk) begin
            if (wr.wr_en) begin
                ring[wr.wr_addr] <= wr.wr_data[c];
            end
            if (rd.rd_en) begin
                rd_word <= ring[rd.rd_addr];
            end
        end

        // data stages carry the payload down the channel's delay line
        always_ff @(posedge memclk) begin
            dly_data[0] <= rd_word;
            for (int s = 1; s < stages; s++) begin
                dly_data[s] <= dly_data[s-1];
            end
        end

        // valids travel alongside the data and are cleared on reset
        always_ff @(posedge memclk) begin
            if (run_rst_i) begin
                dly_vld <= '0;
            end else begin
                dly_vld[0] <= rd_vld;
                for (int s = 1; s < stages; s++) begin
                    dly_vld[s] <= dly_vld[s-1];
                end
            end
        end

        assign dat_o[c]       = dly_data[stages-1];
        assign dat_valid_o[c] = dly_vld[stages-1];
    end

endmodule

`default_nettype wire

//--- hw/pueo_sample_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module pueo_sample_buffer #(
    parameter int nchan         = 4,
    parameter int addr_len      = 10,
    parameter int rd_len        = 12,
    parameter int readout_phase = 0
) (
    input  wire logic                memclk,
    input  wire logic                run_rst_i,
    input  wire logic                run_stop_i,
    input  wire logic                memclk_sync_i,
    // one 72-bit word of six samples per channel, channel 0 lowest
    input  wire logic [nchan*$bits(sample_buffer_pkg::sample_word_t)-1:0] dat_i,
    input  wire logic [addr_len-1:0] req_addr_i,
    input  wire logic                req_valid_i,
    output logic                     req_ready_o,
    output logic                     begin_o,
    output logic [nchan*$bits(sample_buffer_pkg::sample_word_t)-1:0]      dat_o,
    output logic [nchan-1:0]         dat_valid_o,
    output logic                     event_rst_o
);

    write_port_if #(
        .nchan    (nchan),
        .addr_len (addr_len)
    ) wr_if ();

    read_port_if #(
        .addr_len (addr_len)
    ) rd_if ();

    // phase tracking, run control and the write side
    write_sequencer #(
        .nchan         (nchan),
        .addr_len      (addr_len),
        .readout_phase (readout_phase)
    ) i_write_sequencer (
        .memclk        (memclk),
        .run_rst_i     (run_rst_i),
        .run_stop_i    (run_stop_i),
        .memclk_sync_i (memclk_sync_i),
        .dat_i         (dat_i),
        .event_rst_o   (event_rst_o),
        .wr            (wr_if),
        .rd            (rd_if)
    );

    // request handshake and burst addressing
    read_sequencer #(
        .addr_len (addr_len),
        .rd_len   (rd_len)
    ) i_read_sequencer (
        .memclk      (memclk),
        .run_rst_i   (run_rst_i),
        .req_addr_i  (req_addr_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .begin_o     (begin_o),
        .wr          (wr_if),
        .rd          (rd_if)
    );

    // ring memories with the staggered channel outputs
    channel_memory #(
        .nchan    (nchan),
        .addr_len (addr_len)
    ) i_channel_memory (
        .memclk      (memclk),
        .run_rst_i   (run_rst_i),
        .wr          (wr_if),
        .rd          (rd_if),
        .dat_o       (dat_o),
        .dat_valid_o (dat_valid_o)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

// free-running memclk plus a power-on reset held for a few cycles
module tb_clock_gen #(
    parameter int half_period = 10,
    parameter int rst_cycles  = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(half_period) clk_o = ~clk_o;
    end

    // reset drops on the edge after rst_cycles edges have seen it high
    initial begin
        rst_o = 1'b1;
        repeat (rst_cycles) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tb_sample_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_sample_buffer;

    localparam int nchan     = 4;
    localparam int addr_len  = 10;
    localparam int rd_len    = 12;
    localparam int word_bits = 72;
    localparam int depth     = 2 ** addr_len;

    logic                         memclk;
    logic                         gen_rst;
    logic                         go_rst;
    logic                         run_rst_i;
    logic                         run_stop_i;
    logic                         memclk_sync_i;
    logic [nchan*word_bits-1:0]   dat_i;
    logic [addr_len-1:0]          req_addr_i;
    logic                         req_valid_i;
    logic                         req_ready_o;
    logic                         begin_o;
    logic [nchan*word_bits-1:0]   dat_o;
    logic [nchan-1:0]             dat_valid_o;
    logic                         event_rst_o;

    // power-on reset and the restart pulses share the one reset pin
    assign run_rst_i = gen_rst | go_rst;

    tb_clock_gen #(.half_period(10), .rst_cycles(5)) i_tb_clock_gen (
        .clk_o (memclk),
        .rst_o (gen_rst)
    );

    pueo_sample_buffer #(
        .nchan         (nchan),
        .addr_len      (addr_len),
        .rd_len        (rd_len),
        .readout_phase (0)
    ) i_pueo_sample_buffer (
        .memclk        (memclk),
        .run_rst_i     (run_rst_i),
        .run_stop_i    (run_stop_i),
        .memclk_sync_i (memclk_sync_i),
        .dat_i         (dat_i),
        .req_addr_i    (req_addr_i),
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .begin_o       (begin_o),
        .dat_o         (dat_o),
        .dat_valid_o   (dat_valid_o),
        .event_rst_o   (event_rst_o)
    );

    // reference model state
    // cyc is the index of the next rising edge
    logic [nchan*word_bits-1:0] mem_model [depth];
    int                         cyc = 0;
    int                         wr_ptr = 0;
    bit                         m_running = 1'b0;
    bit                         m_known = 1'b0;
    int                         busy_until = -1;
    int                         acc_edge = -1;
    logic [addr_len-1:0]        acc_base;
    int                         begin_cyc = -1;
    bit                         accepted;
    int                         exp_cyc_q [nchan][$];
    logic [word_bits-1:0]       exp_word_q [nchan][$];
    int                         rcv_total [nchan];
    int                         rcv_first;
    int                         errors = 0;
    int                         limit = 1000000;
    bit                         done = 1'b0;

    // test list read from the data file
    byte                        ops [$];
    int                         args [$];
    int                         exps [$];

    // requests go through only in phase 0, while running and idle
    function automatic bit ready_at(int n);
        return m_known && m_running && (n > busy_until) && (n % 4 == 0);
    endfunction

    // each rising edge updates the model from what the DUT sampled and then drives
    task automatic tick();
        int                         e;
        int                         k;
        logic [addr_len-1:0]        ra;
        logic [nchan*word_bits-1:0] nxt;
        @(posedge memclk);
        e = cyc;
        // reads come before the write so a same-address pair sees the old word
        if (acc_edge >= 0 && e >= acc_edge + 2 && e <= acc_edge + 1 + rd_len) begin
            k  = e - acc_edge - 2;
            ra = acc_base + addr_len'(k);
            for (int c = 0; c < nchan; c++) begin
                exp_cyc_q[c].push_back(acc_edge + 4 + k + 2 * c);
                exp_word_q[c].push_back(mem_model[ra][c*word_bits +: word_bits]);
            end
        end
        if (m_running) begin
            mem_model[wr_ptr] = dat_i;
        end
        if (req_valid_i && ready_at(e)) begin
            acc_edge   = e;
            acc_base   = req_addr_i - (req_addr_i % 4);
            busy_until = e + 1 + rd_len;
            begin_cyc  = e + 1;
            accepted   = 1'b1;
        end
        // losing the run or a reset drops any burst
        if (!m_running || run_rst_i) begin
            busy_until = -1;
        end
        // run commands only count on phase 3
        if (e % 4 == 3 && run_rst_i) begin
            m_running = 1'b1;
            m_known   = 1'b1;
            wr_ptr    = 0;
        end else begin
            if (e % 4 == 3 && run_stop_i) begin
                m_running = 1'b0;
            end
            wr_ptr = (wr_ptr + 1) % depth;
        end
        cyc = e + 1;
        for (int i = 0; i < nchan * word_bits / 32; i++) begin
            nxt[i*32 +: 32] = $urandom;
        end
        dat_i         <= nxt;
        memclk_sync_i <= (cyc % 4 == 0);
    endtask

    // outputs are compared in the middle of the cycle, well away from the edges
    always @(negedge memclk) begin
        if (m_known && !done) begin
            assert (req_ready_o === ready_at(cyc)) else begin
                $display("mismatch req_ready_o: got %h expected %h at cycle %0d",
                         req_ready_o, ready_at(cyc), cyc);
                errors++;
            end
            assert (begin_o === (cyc == begin_cyc)) else begin
                $display("mismatch begin_o: got %h expected %h at cycle %0d",
                         begin_o, (cyc == begin_cyc), cyc);
                errors++;
            end
            assert (event_rst_o === !m_running) else begin
                $display("mismatch event_rst_o: got %h expected %h at cycle %0d",
                         event_rst_o, !m_running, cyc);
                errors++;
            end
            for (int c = 0; c < nchan; c++) begin
                // words are counted as the DUT flags them
                if (dat_valid_o[c] === 1'b1) begin
                    rcv_total[c]++;
                    if (c == 0) begin
                        rcv_first++;
                    end
                end
                if (exp_cyc_q[c].size() > 0 && exp_cyc_q[c][0] == cyc) begin
                    assert (dat_valid_o[c] === 1'b1 &&
                            dat_o[c*word_bits +: word_bits] === exp_word_q[c][0]) else begin
                        $display("mismatch dat_o[%0d]: got %h valid %h expected %h at cycle %0d",
                                 c, dat_o[c*word_bits +: word_bits], dat_valid_o[c],
                                 exp_word_q[c][0], cyc);
                        errors++;
                    end
                    void'(exp_cyc_q[c].pop_front());
                    void'(exp_word_q[c].pop_front());
                end else begin
                    assert (dat_valid_o[c] === 1'b0) else begin
                        $display("mismatch dat_valid_o[%0d]: got %h expected 0 at cycle %0d",
                                 c, dat_valid_o[c], cyc);
                        errors++;
                    end
                end
            end
        end
        if (cyc > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // pulses a control pin so that the DUT samples it on a phase-3 edge
    task automatic phase3_pulse(bit is_go);
        while (cyc % 4 != 3) begin
            tick();
        end
        if (is_go) go_rst <= 1'b1;
        else run_stop_i <= 1'b1;
        tick();
        go_rst     <= 1'b0;
        run_stop_i <= 1'b0;
        repeat (2) tick();
    endtask

    initial begin
        int    fd;
        int    n_read;
        int    exp_total;
        string line;
        byte   op;
        int    arg;
        int    expv;
        int    a_edge;
        int    t;
        go_rst        = 1'b0;
        run_stop_i    = 1'b0;
        memclk_sync_i = 1'b1;
        dat_i         = '0;
        req_addr_i    = '0;
        req_valid_i   = 1'b0;
        exp_total     = 0;
        rcv_first     = 0;
        void'($urandom(32'h9348cd09));
        for (int c = 0; c < nchan; c++) begin
            rcv_total[c] = 0;
        end

        fd = $fopen("verif/sample_buffer_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            errors++;
        end else begin
            // the power-on reset counts like one restart in the cycle budget
            t = 16;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() >= 3 && line.substr(0, 0) != "#") begin
                    n_read = $sscanf(line, "%c %d %d", op, arg, expv);
                    if (n_read == 3) begin
                        ops.push_back(op);
                        args.push_back(arg);
                        exps.push_back(expv);
                        if (op == "W") t += arg;
                        else if (op == "R") t += 4 + rd_len + 2 * nchan;
                        else t += 16;
                    end
                end
            end
            $fclose(fd);
            limit = t;
        end

        while (!m_known || gen_rst) begin
            tick();
        end

        for (int i = 0; i < ops.size(); i++) begin
            case (ops[i])
                "W": begin
                    repeat (args[i]) tick();
                    $display("test %0d W %0d: ran %0d cycles", i, args[i], args[i]);
                end
                "R": begin
                    accepted    = 1'b0;
                    rcv_first   = 0;
                    req_addr_i  <= addr_len'(args[i]);
                    req_valid_i <= 1'b1;
                    while (!accepted) begin
                        tick();
                    end
                    req_valid_i <= 1'b0;
                    a_edge = acc_edge;
                    exp_total += exps[i];
                    // channel 0 finishes first and the later channels drain into the next test
                    while (cyc <= a_edge + 4 + rd_len) begin
                        tick();
                    end
                    assert (rcv_first == exps[i]) else begin
                        $display("mismatch words on channel 0: got %h expected %h",
                                 rcv_first, exps[i]);
                        errors++;
                    end
                    $display("test %0d R %0d: accepted at cycle %0d, %0d words",
                             i, args[i], a_edge, rcv_first);
                end
                "S", "G": begin
                    phase3_pulse(ops[i] == "G");
                    @(negedge memclk);
                    assert (event_rst_o === exps[i][0]) else begin
                        $display("mismatch event_rst_o: got %h expected %h",
                                 event_rst_o, exps[i][0]);
                        errors++;
                    end
                    $display("test %0d %c: event_rst_o is %0d", i, ops[i], event_rst_o);
                end
                default: begin
                    $display("unknown opcode in test %0d", i);
                    errors++;
                end
            endcase
        end

        // let the staggered channels drain before the totals are compared
        repeat (4 + 2 * nchan) tick();
        done = 1'b1;
        for (int c = 0; c < nchan; c++) begin
            assert (rcv_total[c] == exp_total) else begin
                $display("mismatch words on channel %0d: got %h expected %h",
                         c, rcv_total[c], exp_total);
                errors++;
            end
        end
        $display("tests run %0d, failed checks %0d", ops.size(), errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/sample_buffer_tests.txt
# opcode argument expected, decimal
# W n 0 runs n cycles, R addr k reads a burst, S 0 e stops, G 0 e restarts
W 40 0
R 13 12
R 5 12
W 20 0
S 0 1
W 30 0
G 0 0
W 30 0
R 2 12
W 1100 0
R 8 12
R 1020 12
W 10 0

//--- files.f
hw/sample_buffer_pkg.sv
hw/sample_buffer_if.sv
hw/write_sequencer.sv
hw/read_sequencer.sv
hw/channel_memory.sv
hw/pueo_sample_buffer.sv
verif/tb_clock_gen.sv
verif/tb_sample_buffer.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_sample_buffer
FILELIST  := files.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
